// File: src/dek_config.svh
`ifndef DEK_CONFIG_SVH
`define DEK_CONFIG_SVH

// Number of decimal digits in the counter
`define DEK_DIGITS 3

// Clk cycles the glow needs to settle after a jump to zero or top
`define DEK_SETTLE_CYCLES 6

// Top register after reset, BCD
`define DEK_TOP_RESET 12'h555

`endif

// File: src/dekPkg.sv
`include "dek_config.svh"

package dekPkg;

	// One tube position as BCD
	typedef logic [3:0] dekDigit_t;

	// Whole count, index 0 is the least significant digit
	typedef dekDigit_t [`DEK_DIGITS-1:0] dekCount_t;

	// Counter core commands, encoding matches the low bits of a CMD write
	typedef enum logic [1:0] {
		OP_INC,
		OP_DEC,
		OP_LOAD,
		OP_CLEAR
	} dekOp_t;

	// Host register map
	typedef enum logic [1:0] {
		REG_CTRL,
		REG_TOP,
		REG_CMD,
		REG_COUNT
	} dekAddr_t;

endpackage

// File: src/counterCmdIf.sv
`timescale 1ns/1ps

// Four-phase command channel from the register block to the counter core
interface counterCmdIf
	import dekPkg::*;
	();

	logic      Req;
	logic      Ack;
	dekOp_t    Op;
	dekCount_t Value;
	logic      TopLimit;
	dekCount_t Top;

	// Register block side issues the command
	modport regs (output Req, Op, Value, TopLimit, Top, input Ack);

	// Counter core side completes it
	modport core (input Req, Op, Value, TopLimit, Top, output Ack);

endinterface

// File: src/dekatronTube.sv
`timescale 1ns/1ps

module dekatronTube
	import dekPkg::*;
(
	input  logic      Clk,
	input  logic      Rst_n,
	input  logic      StepUp,
	input  logic      StepDown,
	input  logic      LoadZero,
	input  logic      LoadTop,
	input  dekDigit_t TopDigit,
	input  dekDigit_t Target,
	output dekDigit_t Digit,
	output logic      AtZero,
	output logic      AtNine,
	output logic      AtTop,
	output logic      Equal
);

	// One glowing cathode out of ten
	logic [9:0] ring;
	dekDigit_t  topPos;

	// A non-BCD top digit parks the glow on nine
	assign topPos = (TopDigit > 4'd9) ? 4'd9 : TopDigit;

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			ring <= 10'b00_0000_0001;
		end else if (LoadZero) begin
			ring <= 10'b00_0000_0001;
		end else if (LoadTop) begin
			ring <= 10'b00_0000_0001 << topPos;
		end else if (StepUp) begin
			ring <= {ring[8:0], ring[9]};
		end else if (StepDown) begin
			ring <= {ring[0], ring[9:1]};
		end
	end

	// Cathode number to BCD
	always_comb begin
		Digit = '0;
		for (int i = 0; i < 10; i++) begin
			if (ring[i]) begin
				Digit = dekDigit_t'(i);
			end
		end
	end

	assign AtZero = ring[0];
	assign AtNine = ring[9];
	assign AtTop  = (Digit == topPos);

	// Invalid target digits count as reached so a load cannot hang
	assign Equal = (Digit == Target) || (Target > 4'd9);

endmodule

// File: src/settleTimer.sv
`timescale 1ns/1ps
`include "dek_config.svh"

module settleTimer (
	input  logic Clk,
	input  logic Rst_n,
	input  logic Start,
	output logic Busy
);

	localparam int Cycles = `DEK_SETTLE_CYCLES;
	localparam int CntW   = $clog2(Cycles + 2);

	logic [CntW-1:0] cnt;

	// Reloads on every Start, even mid-count
	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			cnt <= '0;
		end else if (Start) begin
			cnt <= CntW'(Cycles);
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	assign Busy = (cnt != '0);

endmodule

// File: src/dekatronCounter.sv
`timescale 1ns/1ps
`include "dek_config.svh"

module dekatronCounter
	import dekPkg::*;
(
	input  logic             Clk,
	input  logic             Rst_n,
	counterCmdIf.core        Cmd,
	output dekCount_t        Count
);

	localparam int Digits = `DEK_DIGITS;

	typedef enum logic [2:0] {
		S_IDLE,
		S_STEP_UP,
		S_STEP_DOWN,
		S_LOAD,
		S_LOAD_ZERO,
		S_LOAD_TOP,
		S_DONE
	} state_t;

	state_t state;
	state_t next;

	logic [Digits-1:0] stepUp;
	logic [Digits-1:0] stepDown;
	logic [Digits-1:0] atZero;
	logic [Digits-1:0] atNine;
	logic [Digits-1:0] atTop;
	logic [Digits-1:0] equal;
	logic              loadZero;
	logic              loadTop;
	logic              settleBusy;

	assign loadZero = (state == S_LOAD_ZERO);
	assign loadTop  = (state == S_LOAD_TOP);

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			state <= S_IDLE;
		end else begin
			state <= next;
		end
	end

	always_comb begin
		next = state;
		case (state)
			S_IDLE: begin
				if (Cmd.Req) begin
					case (Cmd.Op)
						OP_INC: begin
							// Top value wraps round to zero
							if (Cmd.TopLimit && (&atTop)) begin
								next = S_LOAD_ZERO;
							end else begin
								next = S_STEP_UP;
							end
						end
						OP_DEC: begin
							if (Cmd.TopLimit && (&atZero)) begin
								next = S_LOAD_TOP;
							end else begin
								next = S_STEP_DOWN;
							end
						end
						OP_LOAD:  next = S_LOAD;
						OP_CLEAR: next = S_LOAD_ZERO;
						default:  next = S_IDLE;
					endcase
				end
			end
			S_STEP_UP:   next = S_DONE;
			S_STEP_DOWN: next = S_DONE;
			S_LOAD: begin
				// One forward step per cycle until every digit matches
				if (&equal) begin
					next = S_DONE;
				end
			end
			S_LOAD_ZERO: next = S_DONE;
			S_LOAD_TOP:  next = S_DONE;
			S_DONE: begin
				if (!settleBusy && !Cmd.Req) begin
					next = S_IDLE;
				end
			end
			default: next = S_IDLE;
		endcase
	end

	// Step pulses ripple upward through the nine and zero flags
	always_comb begin
		logic carryUp;
		logic carryDown;
		carryUp   = (state == S_STEP_UP);
		carryDown = (state == S_STEP_DOWN);
		for (int d = 0; d < Digits; d++) begin
			stepUp[d]   = carryUp || ((state == S_LOAD) && !equal[d]);
			stepDown[d] = carryDown;
			carryUp     = carryUp && atNine[d];
			carryDown   = carryDown && atZero[d];
		end
	end

	// Ack only once the glow has settled
	assign Cmd.Ack = (state == S_DONE) && !settleBusy;

	for (genvar d = 0; d < Digits; d++) begin : gTube
		dekatronTube uTube (
			.Clk      (Clk),
			.Rst_n    (Rst_n),
			.StepUp   (stepUp[d]),
			.StepDown (stepDown[d]),
			.LoadZero (loadZero),
			.LoadTop  (loadTop),
			.TopDigit (Cmd.Top[d]),
			.Target   (Cmd.Value[d]),
			.Digit    (Count[d]),
			.AtZero   (atZero[d]),
			.AtNine   (atNine[d]),
			.AtTop    (atTop[d]),
			.Equal    (equal[d])
		);
	end

	settleTimer uSettle (
		.Clk   (Clk),
		.Rst_n (Rst_n),
		.Start (loadZero || loadTop),
		.Busy  (settleBusy)
	);

endmodule

// File: src/counterRegs.sv
`timescale 1ns/1ps
`include "dek_config.svh"

module counterRegs
	import dekPkg::*;
(
	input  logic      Clk,
	input  logic      Rst_n,
	input  logic      HostReq,
	input  logic      HostWrite,
	input  dekAddr_t  HostAddr,
	input  dekCount_t HostWData,
	output logic      HostAck,
	output dekCount_t HostRData,
	input  dekCount_t Count,
	counterCmdIf.regs Cmd
);

	typedef enum logic [1:0] {
		H_IDLE,
		H_CMD_REQ,
		H_CMD_WAIT,
		H_HOLD
	} hostState_t;

	hostState_t hostState;

	logic      topLimit;
	dekCount_t top;
	dekCount_t loadReg;
	dekOp_t    cmdOp;
	logic      cmdStart;

	assign cmdStart = (hostState == H_IDLE) && HostReq && HostWrite && (HostAddr == REG_CMD);

	// Host handshake and the command channel
	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			hostState <= H_IDLE;
			HostAck   <= 1'b0;
			HostRData <= '0;
			Cmd.Req   <= 1'b0;
			topLimit  <= 1'b0;
			top       <= dekCount_t'(`DEK_TOP_RESET);
		end else begin
			case (hostState)
				H_IDLE: begin
					if (cmdStart) begin
						Cmd.Req   <= 1'b1;
						hostState <= H_CMD_REQ;
					end else if (HostReq) begin
						if (HostWrite) begin
							case (HostAddr)
								REG_CTRL: topLimit <= HostWData[0][0];
								REG_TOP:  top <= HostWData;
								default:  ;
							endcase
						end else begin
							case (HostAddr)
								REG_CTRL:  HostRData <= dekCount_t'(topLimit);
								REG_TOP:   HostRData <= top;
								REG_COUNT: HostRData <= Count;
								default:   HostRData <= '0;
							endcase
						end
						HostAck   <= 1'b1;
						hostState <= H_HOLD;
					end
				end
				H_CMD_REQ: begin
					if (Cmd.Ack) begin
						Cmd.Req   <= 1'b0;
						hostState <= H_CMD_WAIT;
					end
				end
				H_CMD_WAIT: begin
					// Host sees the end of the command only after the core is idle
					if (!Cmd.Ack) begin
						HostAck   <= 1'b1;
						hostState <= H_HOLD;
					end
				end
				H_HOLD: begin
					if (!HostReq) begin
						HostAck   <= 1'b0;
						hostState <= H_IDLE;
					end
				end
				default: hostState <= H_IDLE;
			endcase
		end
	end

	// Load shadow of REG_COUNT and the latched op
	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			loadReg <= '0;
			cmdOp   <= OP_INC;
		end else begin
			if ((hostState == H_IDLE) && HostReq && HostWrite && (HostAddr == REG_COUNT)) begin
				loadReg <= HostWData;
			end
			if (cmdStart) begin
				cmdOp <= dekOp_t'(HostWData[0][1:0]);
			end
		end
	end

	assign Cmd.Op       = cmdOp;
	assign Cmd.Value    = loadReg;
	assign Cmd.TopLimit = topLimit;
	assign Cmd.Top      = top;

endmodule

// File: src/dekatronTop.sv
`timescale 1ns/1ps

module dekatronTop
	import dekPkg::*;
(
	input  logic      Clk,
	input  logic      Rst_n,
	input  logic      HostReq,
	input  logic      HostWrite,
	input  dekAddr_t  HostAddr,
	input  dekCount_t HostWData,
	output logic      HostAck,
	output dekCount_t HostRData
);

	// Live count from the tubes back to the register block
	dekCount_t count;

	counterCmdIf cmdIf ();

	counterRegs uRegs (
		.Clk       (Clk),
		.Rst_n     (Rst_n),
		.HostReq   (HostReq),
		.HostWrite (HostWrite),
		.HostAddr  (HostAddr),
		.HostWData (HostWData),
		.HostAck   (HostAck),
		.HostRData (HostRData),
		.Count     (count),
		.Cmd       (cmdIf.regs)
	);

	// Tube chain with its command FSM
	dekatronCounter uCounter (
		.Clk   (Clk),
		.Rst_n (Rst_n),
		.Cmd   (cmdIf.core),
		.Count (count)
	);

endmodule

// File: tb/tbDekatron.sv
`timescale 1ns/1ps
`include "dek_config.svh"

module tbDekatron
	import dekPkg::*;
();

	// Longest bus transaction covers nine load steps, the settle time and handshake overhead
	localparam int AckLimit = 9 + `DEK_SETTLE_CYCLES + 8;
	// Bus transactions summed over reset, both chains, random loads, top mode and clear
	localparam int NumTransactions = 3 + 10 + 10 + 40 * 5 + 11 + 10;
	localparam int ResetCycles = 10;
	localparam int TimeoutCycles = NumTransactions * AckLimit + ResetCycles;

	logic      Clk;
	logic      Rst_n;
	logic      HostReq;
	logic      HostWrite;
	dekAddr_t  HostAddr;
	dekCount_t HostWData;
	logic      HostAck;
	dekCount_t HostRData;

	logic [31:0] lfsrState = 32'h02dadde8;
	int          cycleCount = 0;
	int          passCount = 0;
	int          failCount = 0;
	int          failAtStart;
	logic        checkPending = 1'b0;
	string       testName;

	// Model of what the DUT should hold
	dekCount_t modelCount;
	dekCount_t loadVal;
	dekCount_t topMdl;
	logic      limitMdl;

	dekCount_t rd;
	dekCount_t v;
	dekOp_t    op;

	dekatronTop DUT (
		.Clk       (Clk),
		.Rst_n     (Rst_n),
		.HostReq   (HostReq),
		.HostWrite (HostWrite),
		.HostAddr  (HostAddr),
		.HostWData (HostWData),
		.HostAck   (HostAck),
		.HostRData (HostRData)
	);

	initial Clk = 1'b0;
	always #20 Clk = ~Clk;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic randBit();
		lfsrState = lfsrNext(lfsrState);
		return lfsrState[0];
	endfunction

	function automatic dekCount_t randCount();
		dekCount_t c;
		dekDigit_t d;
		for (int i = 0; i < `DEK_DIGITS; i++) begin
			d = '0;
			for (int b = 0; b < 4; b++) begin
				d = {d[2:0], randBit()};
			end
			// Fold 10..15 back into BCD
			c[i] = (d > 4'd9) ? d - 4'd10 : d;
		end
		return c;
	endfunction

	function automatic int bcdToInt(input dekCount_t c);
		int n;
		n = 0;
		for (int d = `DEK_DIGITS - 1; d >= 0; d--) begin
			n = n * 10 + int'(c[d]);
		end
		return n;
	endfunction

	function automatic dekCount_t intToBcd(input int n);
		dekCount_t c;
		int r;
		r = n;
		for (int d = 0; d < `DEK_DIGITS; d++) begin
			c[d] = dekDigit_t'(r % 10);
			r = r / 10;
		end
		return c;
	endfunction

	// Next count after one command
	function automatic dekCount_t refNext(input dekCount_t old, input dekOp_t cmd,
		input dekCount_t value, input logic limit, input dekCount_t topVal);
		int modulus;
		dekCount_t res;
		modulus = 1;
		for (int d = 0; d < `DEK_DIGITS; d++) begin
			modulus = modulus * 10;
		end
		case (cmd)
			OP_INC: begin
				if (limit && (old == topVal)) begin
					res = '0;
				end else begin
					res = intToBcd((bcdToInt(old) + 1) % modulus);
				end
			end
			OP_DEC: begin
				if (limit && (old == '0)) begin
					res = topVal;
				end else begin
					res = intToBcd((bcdToInt(old) + modulus - 1) % modulus);
				end
			end
			OP_LOAD: res = value;
			default: res = '0;
		endcase
		return res;
	endfunction

	task automatic checkCount(input string name, input dekCount_t exp, input dekCount_t act);
		if (act !== exp) begin
			$display("** Error %s: count expected %h, actual %h", name, exp, act);
			failCount++;
		end else begin
			passCount++;
		end
	endtask

	task automatic checkReg(input string name, input dekCount_t exp, input dekCount_t act);
		if (act !== exp) begin
			$display("** Error %s: register expected %h, actual %h", name, exp, act);
			failCount++;
		end else begin
			passCount++;
		end
	endtask

	// One four-phase transfer with read data sampled while HostAck is high
	task automatic busCycle(input logic wr, input dekAddr_t addr, input dekCount_t wdata,
		output dekCount_t rdata);
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		rdata = '0;
		@(negedge Clk);
		HostReq   = 1'b1;
		HostWrite = wr;
		HostAddr  = addr;
		HostWData = wdata;
		while (!seen && (n < AckLimit)) begin
			@(negedge Clk);
			seen = HostAck;
			n++;
		end
		if (!seen) begin
			$display("%s: HostAck never rose for access to %s", testName, addr.name());
			failCount++;
		end
		rdata = HostRData;
		HostReq = 1'b0;
		n = 0;
		while (HostAck && (n < AckLimit)) begin
			@(negedge Clk);
			n++;
		end
		if (HostAck) begin
			$display("%s: HostAck stayed high after HostReq fell on access to %s",
				testName, addr.name());
			failCount++;
		end
	endtask

	task automatic hostWrite(input dekAddr_t addr, input dekCount_t data);
		dekCount_t unused;
		busCycle(1'b1, addr, data, unused);
	endtask

	task automatic hostRead(input dekAddr_t addr, output dekCount_t data);
		busCycle(1'b0, addr, '0, data);
	endtask

	// Hands the count check to the checking process and waits for it
	task automatic checkNow();
		checkPending = 1'b1;
		wait (!checkPending);
	endtask

	task automatic writeCount(input dekCount_t value);
		loadVal = value;
		hostWrite(REG_COUNT, value);
	endtask

	task automatic runCmd(input dekOp_t cmd);
		hostWrite(REG_CMD, dekCount_t'(cmd));
		modelCount = refNext(modelCount, cmd, loadVal, limitMdl, topMdl);
		checkNow();
	endtask

	task automatic startTest(input string name);
		testName = name;
		failAtStart = failCount;
	endtask

	task automatic endTest();
		$display("Test %s done, %0d mismatches", testName, failCount - failAtStart);
	endtask

	// Checking process reads the live count back after each command
	initial begin
		dekCount_t readVal;
		forever begin
			wait (checkPending);
			hostRead(REG_COUNT, readVal);
			checkCount(testName, modelCount, readVal);
			checkPending = 1'b0;
		end
	end

	always @(posedge Clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			$display("Run stopped after %0d cycles, the DUT did not finish", cycleCount);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial begin
		Rst_n      = 1'b0;
		HostReq    = 1'b0;
		HostWrite  = 1'b0;
		HostAddr   = REG_CTRL;
		HostWData  = '0;
		modelCount = '0;
		loadVal    = '0;
		topMdl     = dekCount_t'(`DEK_TOP_RESET);
		limitMdl   = 1'b0;
		testName   = "reset";
		repeat (ResetCycles) @(posedge Clk);
		@(negedge Clk);
		Rst_n = 1'b1;

		startTest("reset");
		hostRead(REG_CTRL, rd);
		checkReg("reset ctrl", '0, rd);
		hostRead(REG_TOP, rd);
		checkReg("reset top", topMdl, rd);
		checkNow();
		endTest();

		startTest("inc_chain");
		writeCount(12'h099);
		runCmd(OP_LOAD);
		runCmd(OP_INC);
		writeCount(12'h999);
		runCmd(OP_LOAD);
		runCmd(OP_INC);
		endTest();

		startTest("dec_chain");
		writeCount(12'h100);
		runCmd(OP_LOAD);
		runCmd(OP_DEC);
		writeCount(12'h000);
		runCmd(OP_LOAD);
		runCmd(OP_DEC);
		endTest();

		startTest("random_load");
		for (int i = 0; i < 40; i++) begin
			writeCount(randCount());
			runCmd(OP_LOAD);
			op = randBit() ? OP_INC : OP_DEC;
			runCmd(op);
		end
		endTest();

		startTest("top_limit");
		limitMdl = 1'b1;
		hostWrite(REG_CTRL, 12'h001);
		topMdl = randCount();
		// An all-nines top would wrap the same way with the limit off
		if (topMdl[0] == 4'd9) begin
			topMdl[0] = 4'd8;
		end
		hostWrite(REG_TOP, topMdl);
		hostRead(REG_TOP, rd);
		checkReg("top_limit top", topMdl, rd);
		hostRead(REG_CTRL, rd);
		checkReg("top_limit ctrl", 12'h001, rd);
		writeCount(topMdl);
		runCmd(OP_LOAD);
		// Wraps from the top to zero and back again
		runCmd(OP_INC);
		runCmd(OP_DEC);
		endTest();

		startTest("clear");
		limitMdl = 1'b0;
		hostWrite(REG_CTRL, 12'h000);
		v = randCount();
		// A nonzero start makes the clear visible
		if (v == '0) begin
			v[0] = 4'd1;
		end
		writeCount(v);
		runCmd(OP_LOAD);
		runCmd(OP_CLEAR);
		v = randCount();
		if (v == '0) begin
			v[0] = 4'd1;
		end
		// Shadow write alone must not move the tubes
		writeCount(v);
		checkNow();
		runCmd(OP_LOAD);
		endTest();

		$display("Checks passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+src
src/dekPkg.sv
src/counterCmdIf.sv
src/dekatronTube.sv
src/settleTimer.sv
src/dekatronCounter.sv
src/counterRegs.sv
src/dekatronTop.sv
tb/tbDekatron.sv

// File: Bender.yml
package:
  name: dekatron_counter

sources:
  - include_dirs:
      - src
    files:
      - src/dekPkg.sv
      - src/counterCmdIf.sv
      - src/dekatronTube.sv
      - src/settleTimer.sv
      - src/dekatronCounter.sv
      - src/counterRegs.sv
      - src/dekatronTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tbDekatron.sv
